// File: run.sh
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module DecodeStageTb -f sim.f \
	&& ./obj_dir/VDecodeStageTb | tee /dev/stderr \
	| grep "Simulation completed successfully" > /dev/null \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }

// File: sim.f
src/DecodePkg.sv
src/InstructionDecode.sv
src/ImmediateGenerate.sv
src/RegisterFile.sv
src/DecodeStage.sv
verification/decodeStage_props.sv
verification/DecodeStageTb.sv

// File: src/DecodePkg.sv
`default_nettype none

package DecodePkg;

	// datapath and instruction width
	localparam int XLEN = 32;

	// integer register file geometry
	localparam int REG_COUNT = 32;
	localparam int REG_INDEX_WIDTH = 5;

	// instr[31:7] patterns of the fixed system commands
	localparam logic [24:0] SYS_ECALL_BITS = 25'b0000000_00000_00000_000_00000;
	localparam logic [24:0] SYS_EBREAK_BITS = 25'b0000000_00001_00000_000_00000;
	localparam logic [24:0] SYS_MRET_BITS = 25'b0011000_00010_00000_000_00000;

	// major opcodes of RV32I
	typedef enum logic [6:0] {
		OP_LUI = 7'b0110111,
		OP_AUIPC = 7'b0010111,
		OP_JAL = 7'b1101111,
		OP_JALR = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD = 7'b0000011,
		OP_STORE = 7'b0100011,
		OP_ALU_IMM = 7'b0010011,
		OP_ALU = 7'b0110011,
		OP_FENCE = 7'b0001111,
		OP_SYSTEM = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {
		IMM_NONE = 3'd0,
		IMM_I = 3'd1,
		IMM_S = 3'd2,
		IMM_B = 3'd3,
		IMM_U = 3'd4,
		IMM_J = 3'd5
	} immFormat_t;

	// class flags, msb first
	typedef struct packed {
		logic isLUI;
		logic isAUIPC;
		logic isJAL;
		logic isJALR;
		logic isBranch;
		logic isLoad;
		logic isStore;
		logic isALUImmBase;
		logic isALUImmNormal;
		logic isALUImmShift;
		logic isALUImm;
		logic isALU;
		logic isFENCE;
		logic isSystem;
		logic isCSR;
		logic isCSRIMM;
		logic isCSRRW;
		logic isCSRRS;
		logic isCSRRC;
		logic isECALL;
		logic isEBREAK;
		logic isRET;
		logic isCompressed;
		logic invalidInstruction;
	} instrClass_t;

	typedef struct packed {
		opcode_t opcode;
		logic [REG_INDEX_WIDTH-1:0] rdIndex;
		logic [REG_INDEX_WIDTH-1:0] rs1Index;
		logic [REG_INDEX_WIDTH-1:0] rs2Index;
		logic [2:0] funct3;
		logic [6:0] funct7;
	} instrFields_t;

	// payload handed to execute
	typedef struct packed {
		logic decodeValid;
		instrFields_t fields;
		instrClass_t instrClass;
		immFormat_t immFormat;
		logic [XLEN-1:0] immediate;
		logic [XLEN-1:0] rs1Data;
		logic [XLEN-1:0] rs2Data;
	} decodedInstr_t;

	typedef struct packed {
		logic enable;
		logic [REG_INDEX_WIDTH-1:0] index;
		logic [XLEN-1:0] data;
	} regWrite_t;

endpackage

`default_nettype wire

// File: src/DecodeStage.sv
`default_nettype none

module DecodeStage (
	input wire clk,
	input wire rst,
	input wire [DecodePkg::XLEN-1:0] instruction,
	input wire fetchValid,
	input wire stall,
	input wire DecodePkg::regWrite_t writeBack,
	output DecodePkg::decodedInstr_t decoded
);
	import DecodePkg::*;

	instrFields_t fields;
	instrClass_t instrClass;
	immFormat_t immFormat;
	logic [XLEN-1:0] immediate;
	logic [XLEN-1:0] rs1Data;
	logic [XLEN-1:0] rs2Data;
	logic decoderStall;
	logic accept;
	decodedInstr_t nextDecoded;

	// a word is taken only when fetch offers it and nothing stalls
	assign accept = fetchValid && !stall;
	assign decoderStall = !accept;

	InstructionDecode instructionDecode (
		.currentInstruction(instruction),
		.stall(decoderStall),
		.fields(fields),
		.instrClass(instrClass)
	);

	// opcode is already zero for a bubble, so the immediate is too
	ImmediateGenerate immediateGenerate (
		.currentInstruction(instruction),
		.opcode(fields.opcode),
		.immFormat(immFormat),
		.immediate(immediate)
	);

	// zeroed indices of a bubble read x0
	RegisterFile registerFile (
		.clk(clk),
		.rst(rst),
		.rs1Index(fields.rs1Index),
		.rs2Index(fields.rs2Index),
		.writeBack(writeBack),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data)
	);

	always_comb begin
		nextDecoded.decodeValid = accept;
		nextDecoded.fields = fields;
		nextDecoded.instrClass = instrClass;
		nextDecoded.immFormat = immFormat;
		nextDecoded.immediate = immediate;
		nextDecoded.rs1Data = rs1Data;
		nextDecoded.rs2Data = rs2Data;
	end

	// decode to execute pipeline register
	always_ff @(posedge clk) begin
		if (rst) begin
			decoded <= '0;
		end else begin
			decoded <= nextDecoded;
		end
	end

endmodule

`default_nettype wire

// File: src/ImmediateGenerate.sv
`default_nettype none

module ImmediateGenerate (
	input wire [DecodePkg::XLEN-1:0] currentInstruction,
	input wire DecodePkg::opcode_t opcode,
	output DecodePkg::immFormat_t immFormat,
	output logic [DecodePkg::XLEN-1:0] immediate
);
	import DecodePkg::*;

	logic sign;

	assign sign = currentInstruction[31];

	// format from the major opcode
	always_comb begin
		case (opcode)
			OP_JALR, OP_LOAD, OP_ALU_IMM, OP_SYSTEM: immFormat = IMM_I;
			OP_STORE: immFormat = IMM_S;
			OP_BRANCH: immFormat = IMM_B;
			OP_LUI, OP_AUIPC: immFormat = IMM_U;
			OP_JAL: immFormat = IMM_J;
			default: immFormat = IMM_NONE;
		endcase
	end

	// sign bit is always instr[31]
	always_comb begin
		case (immFormat)
			IMM_I: immediate = {{20{sign}}, currentInstruction[31:20]};
			IMM_S: immediate = {{20{sign}}, currentInstruction[31:25], currentInstruction[11:7]};
			IMM_B: begin
				immediate = {{19{sign}}, sign, currentInstruction[7],
					currentInstruction[30:25], currentInstruction[11:8], 1'b0};
			end
			// upper twenty bits, low part zero
			IMM_U: immediate = {currentInstruction[31:12], 12'b0};
			IMM_J: begin
				immediate = {{11{sign}}, sign, currentInstruction[19:12],
					currentInstruction[20], currentInstruction[30:21], 1'b0};
			end
			default: immediate = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: src/InstructionDecode.sv
`default_nettype none

module InstructionDecode (
	input wire [DecodePkg::XLEN-1:0] currentInstruction,
	input wire stall,
	output DecodePkg::instrFields_t fields,
	output DecodePkg::instrClass_t instrClass
);
	import DecodePkg::*;

	instrFields_t rawFields;
	instrClass_t rawClass;
	logic [24:0] systemBits;
	logic anyClass;
	logic validSystemCommand;

	// plain bit slices
	always_comb begin
		rawFields.opcode = opcode_t'(currentInstruction[6:0]);
		rawFields.rdIndex = currentInstruction[11:7];
		rawFields.rs1Index = currentInstruction[19:15];
		rawFields.rs2Index = currentInstruction[24:20];
		rawFields.funct3 = currentInstruction[14:12];
		rawFields.funct7 = currentInstruction[31:25];
	end

	assign systemBits = currentInstruction[31:7];

	// major classes with funct3 / funct7 legality
	always_comb begin
		logic [2:0] f3;
		logic [6:0] f7;
		opcode_t op;

		f3 = rawFields.funct3;
		f7 = rawFields.funct7;
		op = rawFields.opcode;
		rawClass = '0;

		rawClass.isCompressed = currentInstruction[1:0] != 2'b11;
		rawClass.isLUI = op == OP_LUI;
		rawClass.isAUIPC = op == OP_AUIPC;
		rawClass.isJAL = op == OP_JAL;
		rawClass.isJALR = (op == OP_JALR) && (f3 == 3'b000);
		// funct3 010 and 011 are unused branch encodings
		rawClass.isBranch = (op == OP_BRANCH) && (f3 != 3'b010) && (f3 != 3'b011);
		rawClass.isLoad = (op == OP_LOAD) && (f3 != 3'b011) && (f3 != 3'b110)
			&& (f3 != 3'b111);
		rawClass.isStore = (op == OP_STORE) && (f3 inside {3'b000, 3'b001, 3'b010});

		rawClass.isALUImmBase = op == OP_ALU_IMM;
		rawClass.isALUImmNormal = rawClass.isALUImmBase && (f3 != 3'b001) && (f3 != 3'b101);
		// slli needs funct7 zero, srli/srai allow bit 30
		rawClass.isALUImmShift = rawClass.isALUImmBase
			&& (((f3 == 3'b001) && (f7 == 7'b0000000))
			|| ((f3 == 3'b101) && ((f7 == 7'b0000000) || (f7 == 7'b0100000))));
		rawClass.isALUImm = rawClass.isALUImmNormal || rawClass.isALUImmShift;

		// only add/sub and srl/sra use the alternate funct7
		rawClass.isALU = (op == OP_ALU) && ((f7 == 7'b0000000)
			|| ((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101))));
		rawClass.isFENCE = (op == OP_FENCE) && (f3 == 3'b000);
		rawClass.isSystem = op == OP_SYSTEM;

		// csr variants
		rawClass.isCSR = rawClass.isSystem && (f3 != 3'b000);
		rawClass.isCSRIMM = rawClass.isCSR && f3[2];
		rawClass.isCSRRW = rawClass.isCSR && (f3[1:0] == 2'b01);
		rawClass.isCSRRS = rawClass.isCSR && (f3[1:0] == 2'b10);
		rawClass.isCSRRC = rawClass.isCSR && (f3[1:0] == 2'b11);

		// fixed system words, everything above the opcode must match
		rawClass.isECALL = rawClass.isSystem && (systemBits == SYS_ECALL_BITS);
		rawClass.isEBREAK = rawClass.isSystem && (systemBits == SYS_EBREAK_BITS);
		rawClass.isRET = rawClass.isSystem && (systemBits == SYS_MRET_BITS);

		rawClass.invalidInstruction = 1'b0;
	end

	// only the top level classes count, not the alu-imm base match
	assign anyClass = rawClass.isLUI || rawClass.isAUIPC || rawClass.isJAL
		|| rawClass.isJALR || rawClass.isBranch || rawClass.isLoad
		|| rawClass.isStore || rawClass.isALUImm || rawClass.isALU
		|| rawClass.isFENCE || rawClass.isSystem;

	assign validSystemCommand = rawClass.isCSR || rawClass.isECALL
		|| rawClass.isEBREAK || rawClass.isRET;

	// stalled word decodes as all zeros
	always_comb begin
		if (stall) begin
			fields = '0;
			instrClass = '0;
		end else begin
			fields = rawFields;
			instrClass = rawClass;
			instrClass.invalidInstruction = rawClass.isCompressed || !anyClass
				|| (rawClass.isSystem && !validSystemCommand);
		end
	end

endmodule

`default_nettype wire

// File: src/RegisterFile.sv
`default_nettype none

module RegisterFile (
	input wire clk,
	input wire rst,
	input wire [DecodePkg::REG_INDEX_WIDTH-1:0] rs1Index,
	input wire [DecodePkg::REG_INDEX_WIDTH-1:0] rs2Index,
	input wire DecodePkg::regWrite_t writeBack,
	output logic [DecodePkg::XLEN-1:0] rs1Data,
	output logic [DecodePkg::XLEN-1:0] rs2Data
);
	import DecodePkg::*;

	logic [XLEN-1:0] registers [REG_COUNT];
	logic writeActive;

	// x0 is never written
	assign writeActive = writeBack.enable && (writeBack.index != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				registers[i] <= '0;
			end
		end else if (writeActive) begin
			registers[writeBack.index] <= writeBack.data;
		end
	end

	// read with same-cycle bypass of the pending write
	always_comb begin
		if (rs1Index == '0) begin
			rs1Data = '0;
		end else if (writeActive && (writeBack.index == rs1Index)) begin
			rs1Data = writeBack.data;
		end else begin
			rs1Data = registers[rs1Index];
		end
	end

	always_comb begin
		if (rs2Index == '0) begin
			rs2Data = '0;
		end else if (writeActive && (writeBack.index == rs2Index)) begin
			rs2Data = writeBack.data;
		end else begin
			rs2Data = registers[rs2Index];
		end
	end

endmodule

`default_nettype wire

// File: verification/DecodeStageTb.sv
`default_nettype none

module DecodeStageTb;
	timeunit 1ns;
	timeprecision 100ps;
	import DecodePkg::*;

	localparam int PERIOD = 4;
	localparam int TEST_CYCLES = 4000;
	localparam int RESET_CYCLE = 2500;
	localparam int WATCHDOG_TIME = (TEST_CYCLES + 20) * PERIOD + 100;

	logic clk;
	logic rst;
	logic [XLEN-1:0] instruction;
	logic fetchValid;
	logic stall;
	regWrite_t writeBack;
	decodedInstr_t decoded;

	logic [31:0] rngState;
	logic [XLEN-1:0] modelRegs [REG_COUNT];
	decodedInstr_t expectedQueue [$];
	string nameQueue [$];
	int errorCount;
	int checkCount;

	DecodeStage u_dut (
		.clk(clk),
		.rst(rst),
		.instruction(instruction),
		.fetchValid(fetchValid),
		.stall(stall),
		.writeBack(writeBack),
		.decoded(decoded)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// register read as seen through the writeback bypass
	function automatic logic [31:0] readModel(input logic [4:0] idx, input regWrite_t wb);
		if (idx == 5'd0) return '0;
		if (wb.enable && (wb.index == idx)) return wb.data;
		return modelRegs[idx];
	endfunction

	function automatic decodedInstr_t modelDecode(input logic [31:0] word, input logic accept,
		input regWrite_t wb);
		decodedInstr_t exp;
		logic [6:0] op;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [31:0] iImm;
		logic [31:0] sImm;
		logic topClass;
		logic sysCommand;

		exp = '0;
		if (!accept) return exp;
		op = word[6:0];
		f3 = word[14:12];
		f7 = word[31:25];
		exp.decodeValid = 1'b1;
		exp.fields.opcode = opcode_t'(op);
		exp.fields.rdIndex = word[11:7];
		exp.fields.rs1Index = word[19:15];
		exp.fields.rs2Index = word[24:20];
		exp.fields.funct3 = f3;
		exp.fields.funct7 = f7;

		exp.instrClass.isCompressed = word[1:0] != 2'b11;
		case (op)
			7'b0110111: exp.instrClass.isLUI = 1'b1;
			7'b0010111: exp.instrClass.isAUIPC = 1'b1;
			7'b1101111: exp.instrClass.isJAL = 1'b1;
			7'b1100111: exp.instrClass.isJALR = f3 == 3'd0;
			7'b1100011: exp.instrClass.isBranch = (f3 != 3'd2) && (f3 != 3'd3);
			7'b0000011: exp.instrClass.isLoad = (f3 <= 3'd2) || (f3 == 3'd4) || (f3 == 3'd5);
			7'b0100011: exp.instrClass.isStore = f3 <= 3'd2;
			7'b0010011: begin
				exp.instrClass.isALUImmBase = 1'b1;
				exp.instrClass.isALUImmNormal = (f3 != 3'd1) && (f3 != 3'd5);
				exp.instrClass.isALUImmShift = ((f3 == 3'd1) && (f7 == 7'h00))
					|| ((f3 == 3'd5) && ((f7 == 7'h00) || (f7 == 7'h20)));
				exp.instrClass.isALUImm = exp.instrClass.isALUImmNormal
					|| exp.instrClass.isALUImmShift;
			end
			7'b0110011: begin
				exp.instrClass.isALU = (f7 == 7'h00)
					|| ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
			end
			7'b0001111: exp.instrClass.isFENCE = f3 == 3'd0;
			7'b1110011: begin
				exp.instrClass.isSystem = 1'b1;
				exp.instrClass.isCSR = f3 != 3'd0;
				exp.instrClass.isCSRIMM = f3[2];
				exp.instrClass.isCSRRW = f3[1:0] == 2'd1;
				exp.instrClass.isCSRRS = f3[1:0] == 2'd2;
				exp.instrClass.isCSRRC = f3[1:0] == 2'd3;
				exp.instrClass.isECALL = word == 32'h00000073;
				exp.instrClass.isEBREAK = word == 32'h00100073;
				exp.instrClass.isRET = word == 32'h30200073;
			end
			default: ;
		endcase
		topClass = exp.instrClass.isLUI || exp.instrClass.isAUIPC || exp.instrClass.isJAL
			|| exp.instrClass.isJALR || exp.instrClass.isBranch || exp.instrClass.isLoad
			|| exp.instrClass.isStore || exp.instrClass.isALUImm || exp.instrClass.isALU
			|| exp.instrClass.isFENCE || exp.instrClass.isSystem;
		sysCommand = exp.instrClass.isCSR || exp.instrClass.isECALL
			|| exp.instrClass.isEBREAK || exp.instrClass.isRET;
		exp.instrClass.invalidInstruction = exp.instrClass.isCompressed || !topClass
			|| (exp.instrClass.isSystem && !sysCommand);

		// B and J reuse the S and I shapes with a few bits moved
		iImm = $signed(word) >>> 20;
		sImm = {iImm[31:5], word[11:7]};
		case (op)
			7'b1100111, 7'b0000011, 7'b0010011, 7'b1110011: begin
				exp.immFormat = IMM_I;
				exp.immediate = iImm;
			end
			7'b0100011: begin
				exp.immFormat = IMM_S;
				exp.immediate = sImm;
			end
			7'b1100011: begin
				exp.immFormat = IMM_B;
				exp.immediate = {sImm[31:12], word[7], sImm[10:1], 1'b0};
			end
			7'b0110111, 7'b0010111: begin
				exp.immFormat = IMM_U;
				exp.immediate = {word[31:12], 12'h000};
			end
			7'b1101111: begin
				exp.immFormat = IMM_J;
				exp.immediate = {iImm[31:20], word[19:12], word[20], iImm[10:1], 1'b0};
			end
			default: ;
		endcase

		exp.rs1Data = readModel(word[19:15], wb);
		exp.rs2Data = readModel(word[24:20], wb);
		return exp;
	endfunction

	// any word, often compressed or an unknown opcode
	function automatic logic [31:0] randomWord();
		logic [31:0] w;
		logic [31:0] sel;

		w = nextRandom();
		sel = nextRandom();
		if (sel[0]) w[1:0] = 2'b11;
		return w;
	endfunction

	function automatic logic [31:0] legalWord();
		logic [31:0] w;
		logic [31:0] choose;
		int sel;

		w = nextRandom();
		choose = nextRandom();
		sel = int'(nextRandom() % 32'd11);
		case (sel)
			0: w[6:0] = OP_LUI;
			1: w[6:0] = OP_AUIPC;
			2: w[6:0] = OP_JAL;
			3: w[6:0] = OP_JALR;
			4: w[6:0] = OP_BRANCH;
			5: w[6:0] = OP_LOAD;
			6: w[6:0] = OP_STORE;
			7: w[6:0] = OP_ALU_IMM;
			8: w[6:0] = OP_ALU;
			9: w[6:0] = OP_FENCE;
			default: w[6:0] = OP_SYSTEM;
		endcase
		// half the time a funct7 that alu and shift words accept
		if (choose[0]) w[31:25] = choose[1] ? 7'h20 : 7'h00;
		return w;
	endfunction

	function automatic logic [31:0] systemWord();
		logic [31:0] w;
		int sel;

		w = nextRandom();
		sel = int'(nextRandom() % 32'd5);
		w[6:0] = 7'h73;
		case (sel)
			0: w = 32'h00000073;
			1: w = 32'h00100073;
			2: w = 32'h30200073;
			3: w[14:12] = 3'd0;
			default: ;
		endcase
		return w;
	endfunction

	task automatic checkValue(input string testName, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			errorCount++;
			$display("FAILED %s %s expected %h actual %h", testName, what, expected, actual);
		end
	endtask

	task automatic checkOutput();
		decodedInstr_t expected;
		string testName;

		if (expectedQueue.size() == 0) return;
		expected = expectedQueue.pop_front();
		testName = nameQueue.pop_front();
		checkValue(testName, "decodeValid", 32'(expected.decodeValid), 32'(decoded.decodeValid));
		checkValue(testName, "fields", 32'(expected.fields), 32'(decoded.fields));
		checkValue(testName, "class", 32'(expected.instrClass), 32'(decoded.instrClass));
		checkValue(testName, "immFormat", 32'(expected.immFormat), 32'(decoded.immFormat));
		checkValue(testName, "immediate", expected.immediate, decoded.immediate);
		checkValue(testName, "rs1Data", expected.rs1Data, decoded.rs1Data);
		checkValue(testName, "rs2Data", expected.rs2Data, decoded.rs2Data);
	endtask

	task automatic driveCycle(input int cycle);
		logic [31:0] r;
		string testName;
		decodedInstr_t expected;

		r = nextRandom();
		rst = (cycle == RESET_CYCLE) || (cycle == RESET_CYCLE + 1);
		fetchValid = r[2:0] != 3'd0;
		stall = r[5:3] == 3'd0;
		case (r[8:6])
			3'd0, 3'd1: begin
				instruction = randomWord();
				testName = "random";
			end
			3'd7: begin
				instruction = systemWord();
				testName = "system";
			end
			default: begin
				instruction = legalWord();
				testName = "legal";
			end
		endcase
		// steer some writes onto the read ports to hit the bypass
		writeBack.enable = r[9];
		writeBack.data = nextRandom();
		if (r[11:10] == 2'd0) begin
			writeBack.index = instruction[19:15];
		end else if (r[11:10] == 2'd1) begin
			writeBack.index = instruction[24:20];
		end else begin
			writeBack.index = 5'(nextRandom());
		end

		if (rst) begin
			expected = '0;
			testName = "reset";
		end else begin
			expected = modelDecode(instruction, fetchValid && !stall, writeBack);
			if (!(fetchValid && !stall)) testName = "bubble";
		end
		expectedQueue.push_back(expected);
		nameQueue.push_back(testName);

		// array state after the coming edge
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				modelRegs[i] = '0;
			end
		end else if (writeBack.enable && (writeBack.index != 5'd0)) begin
			modelRegs[writeBack.index] = writeBack.data;
		end
	endtask

	initial begin
		decodedInstr_t resetValue;

		rngState = 32'h0a124edc;
		errorCount = 0;
		checkCount = 0;
		rst = 1'b1;
		instruction = '0;
		fetchValid = 1'b0;
		stall = 1'b0;
		writeBack = '0;
		for (int i = 0; i < REG_COUNT; i++) begin
			modelRegs[i] = '0;
		end
		resetValue = '0;
		expectedQueue.push_back(resetValue);
		nameQueue.push_back("reset");

		repeat (2) @(posedge clk);
		for (int cycle = 0; cycle < TEST_CYCLES; cycle++) begin
			@(negedge clk);
			checkOutput();
			driveCycle(cycle);
		end
		@(negedge clk);
		checkOutput();

		$display("checks %0d errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("watchdog expired before the test loop finished");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/decodeStage_props.sv
`default_nettype none

module decodeStage_props (
	input wire clk,
	input wire rst,
	input wire fetchValid,
	input wire stall,
	input wire DecodePkg::decodedInstr_t decoded
);
	timeunit 1ns;
	timeprecision 100ps;

	logic anyLegalClass;

	// system words are left out, an unknown system word keeps isSystem
	assign anyLegalClass = decoded.instrClass.isLUI || decoded.instrClass.isAUIPC
		|| decoded.instrClass.isJAL || decoded.instrClass.isJALR
		|| decoded.instrClass.isBranch || decoded.instrClass.isLoad
		|| decoded.instrClass.isStore || decoded.instrClass.isALUImm
		|| decoded.instrClass.isALU || decoded.instrClass.isFENCE
		|| decoded.instrClass.isCSR || decoded.instrClass.isECALL
		|| decoded.instrClass.isEBREAK || decoded.instrClass.isRET;

	resetClears: assert property (@(posedge clk) rst |=> decoded == '0)
		else $error("decoded register not cleared one cycle after reset");

	validFollowsAccept: assert property (@(posedge clk)
		!rst |=> decoded.decodeValid == $past(fetchValid && !stall))
		else $error("decodeValid does not follow the accepted word");

	invalidHasNoClass: assert property (@(posedge clk)
		decoded.instrClass.invalidInstruction |-> !anyLegalClass)
		else $error("invalid instruction carries a class flag");

	// x0 reads zero
	rs1ZeroReadsZero: assert property (@(posedge clk)
		decoded.fields.rs1Index == '0 |-> decoded.rs1Data == '0)
		else $error("rs1 data nonzero for index zero");

endmodule

bind DecodeStage decodeStage_props props (
	.clk(clk),
	.rst(rst),
	.fetchValid(fetchValid),
	.stall(stall),
	.decoded(decoded)
);

`default_nettype wire
